// ==== Makefile ====
# Verilator simulation of the I2C target testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_slave
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/i2c_bit_counter.sv ====
////////////////////////////////////////////////////////////////////////////
// counts the bits left in the current byte
// loaded and stepped by FSM strobes, reports zero back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2c_slave_consts.svh"

module i2c_bit_counter (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  start,
    i2c_ctl_if.dp ctl
);

    i2c_slave_pkg::bit_count_t count;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (ctl.load_count) begin
            count <= i2c_slave_pkg::bit_count_t'(`I2C_DATA_LEN - 1);
        end else if (ctl.dec_count) begin
            count <= count - 1'b1;
        end
    end

    assign ctl.count_zero = (count == '0);

endmodule

`default_nettype wire

// ==== logic/i2c_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// types for the bytes that travel on the I2C bus
// the receive word is a union since the same shift register holds the
// address frame first and data bytes after it
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "i2c_slave_consts.svh"

package i2c_bus_pkg;

    typedef logic [`I2C_DATA_LEN-1:0] i2c_byte_t;

    typedef logic [`I2C_ADDR_LEN-1:0] i2c_addr_t;

    // first byte after start: address, then read-not-write
    typedef struct packed {
        i2c_addr_t addr;
        logic      rd_nwr;
    } i2c_addr_frame_t;

    typedef union packed {
        i2c_byte_t       data;
        i2c_addr_frame_t frame;
    } i2c_rx_word_u;

endpackage

`default_nettype wire

// ==== logic/i2c_byte_shifter.sv ====
////////////////////////////////////////////////////////////////////////////
// byte datapath of the I2C target
// receive shift register with address compare and direction bit,
// transmit shift register and the registered SDA drive
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2c_slave_consts.svh"

module i2c_byte_shifter (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start,
    input  i2c_bus_pkg::i2c_byte_t outbound_data,
    input  logic                   addr_or_data_load,
    i2c_line_if.dst                line,
    i2c_ctl_if.dp                  ctl,
    output i2c_bus_pkg::i2c_byte_t incoming_data,
    output logic                   sda_out
);

    i2c_bus_pkg::i2c_addr_t    target_addr;
    i2c_bus_pkg::i2c_rx_word_u rx_word;
    i2c_bus_pkg::i2c_byte_t    tx_byte;

    // target address comes with the host start pulse
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            target_addr <= '0;
        end else if (start) begin
            target_addr <= outbound_data[`I2C_ADDR_LEN-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // receive side
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_word.data <= '0;
            ctl.dir_read <= 1'b0;
        end else begin
            if (ctl.shift_in) begin
                rx_word.data <= {rx_word.data[`I2C_DATA_LEN-2:0], line.sda_level};
            end
            if (ctl.load_dir) begin
                ctl.dir_read <= rx_word.frame.rd_nwr;
            end
        end
    end

    assign ctl.addr_hit  = (rx_word.frame.addr == target_addr);
    assign incoming_data = rx_word.data;

    //////////////////////////////////////////////////////////////////////////
    // transmit side
    //////////////////////////////////////////////////////////////////////////

    // fill with ones so SDA is released after the last bit
    always_ff @(posedge clk) begin
        if (addr_or_data_load) begin
            tx_byte <= outbound_data;
        end else if (ctl.shift_out) begin
            tx_byte <= {tx_byte[`I2C_DATA_LEN-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sda_out <= 1'b0;
        end else if (ctl.sda_high) begin
            sda_out <= 1'b1;
        end else if (ctl.sda_low) begin
            sda_out <= 1'b0;
        end else if (ctl.shift_out) begin
            sda_out <= tx_byte[`I2C_DATA_LEN-1];
        end
    end

endmodule

`default_nettype wire

// ==== logic/i2c_ctl_if.sv ====
////////////////////////////////////////////////////////////////////////////
// FSM command strobes to the bit counter and byte shifter
// with the status they report back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface i2c_ctl_if;

    // counter commands
    logic load_count;
    logic dec_count;

    // shifter commands, sda_high > sda_low > shift_out
    logic shift_in;
    logic load_dir;
    logic shift_out;
    logic sda_low;
    logic sda_high;

    // status
    logic count_zero;
    logic addr_hit;
    logic dir_read;

    modport ctl (
        output load_count, dec_count, shift_in, load_dir, shift_out, sda_low, sda_high,
        input  count_zero, addr_hit, dir_read
    );

    modport dp (
        input  load_count, dec_count, shift_in, load_dir, shift_out, sda_low, sda_high,
        output count_zero, addr_hit, dir_read
    );

endinterface

`default_nettype wire

// ==== logic/i2c_line_if.sv ====
////////////////////////////////////////////////////////////////////////////
// sampled bus levels and edge events
// driven by the line sampler, read by the FSM and the byte shifter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface i2c_line_if;

    // oldest synchronizer stage
    logic sda_level;
    logic scl_level;

    // single-cycle event pulses
    logic scl_rise;
    logic scl_fall;
    logic sda_fall;
    logic start_seen;

    modport src (
        output sda_level, scl_level, scl_rise, scl_fall, sda_fall, start_seen
    );

    modport dst (
        input  sda_level, scl_level, scl_rise, scl_fall, sda_fall, start_seen
    );

endinterface

`default_nettype wire

// ==== logic/i2c_line_sampler.sv ====
////////////////////////////////////////////////////////////////////////////
// synchronizes SDA and SCL into the core clock domain
// produces registered edge pulses and the start condition
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2c_slave_consts.svh"

module i2c_line_sampler (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    sda_in,
    input  logic    scl_in,
    i2c_line_if.src line
);

    localparam int msb = `I2C_SYNC_DEPTH - 1;

    logic [`I2C_SYNC_DEPTH-1:0] sda_sr;
    logic [`I2C_SYNC_DEPTH-1:0] scl_sr;

    // idle bus is high, so start from ones and avoid a false edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sda_sr <= '1;
            scl_sr <= '1;
        end else begin
            sda_sr <= {sda_sr[msb-1:0], sda_in};
            scl_sr <= {scl_sr[msb-1:0], scl_in};
        end
    end

    assign line.sda_level = sda_sr[msb];
    assign line.scl_level = scl_sr[msb];

    // edges from the two oldest stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            line.scl_rise   <= 1'b0;
            line.scl_fall   <= 1'b0;
            line.sda_fall   <= 1'b0;
            line.start_seen <= 1'b0;
        end else begin
            line.scl_rise   <= ~scl_sr[msb] & scl_sr[msb-1];
            line.scl_fall   <= scl_sr[msb] & ~scl_sr[msb-1];
            line.sda_fall   <= sda_sr[msb] & ~sda_sr[msb-1];
            // SDA falling while SCL stays high
            line.start_seen <= line.sda_fall & scl_sr[msb];
        end
    end

endmodule

`default_nettype wire

// ==== logic/i2c_slave.sv ====
////////////////////////////////////////////////////////////////////////////
// I2C target controller, top level
// host pulses start with the address on outbound_data, then answers
// data_ready / data_request with addr_or_data_load
// sda_out and scl_out are open-drain style, 0 pulls the line low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "i2c_slave_consts.svh"

module i2c_slave (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start,
    input  logic [`I2C_DATA_LEN-1:0] outbound_data,
    input  logic                     addr_or_data_load,
    output logic                     data_request,
    output logic                     i2c_addr_match,
    output logic                     data_ready,
    output logic [`I2C_DATA_LEN-1:0] incoming_data,
    output logic                     no_ack_flag,
    input  logic                     sda_in,
    input  logic                     scl_in,
    output logic                     sda_out,
    output logic                     scl_out
);

    i2c_line_if line_if ();
    i2c_ctl_if  ctl_if ();

    i2c_line_sampler line_sampler_i (
        .clk     (clk),
        .reset_n (reset_n),
        .sda_in  (sda_in),
        .scl_in  (scl_in),
        .line    (line_if.src)
    );

    i2c_bit_counter bit_counter_i (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (start),
        .ctl     (ctl_if.dp)
    );

    i2c_byte_shifter byte_shifter_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .start             (start),
        .outbound_data     (outbound_data),
        .addr_or_data_load (addr_or_data_load),
        .line              (line_if.dst),
        .ctl               (ctl_if.dp),
        .incoming_data     (incoming_data),
        .sda_out           (sda_out)
    );

    i2c_slave_fsm slave_fsm_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .start             (start),
        .addr_or_data_load (addr_or_data_load),
        .line              (line_if.dst),
        .ctl               (ctl_if.ctl),
        .data_ready        (data_ready),
        .data_request      (data_request),
        .i2c_addr_match    (i2c_addr_match),
        .no_ack_flag       (no_ack_flag),
        .scl_out           (scl_out)
    );

endmodule

`default_nettype wire

// ==== logic/i2c_slave_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// width constants for the I2C target controller
// included by the packages and by every module that sizes a register
// from the byte, address or synchronizer length
////////////////////////////////////////////////////////////////////////////

`ifndef I2C_SLAVE_CONSTS_SVH
`define I2C_SLAVE_CONSTS_SVH

// bits per byte on the bus
`define I2C_DATA_LEN 8

// 7-bit target address
`define I2C_ADDR_LEN 7

// stages in the SDA/SCL input synchronizer
`define I2C_SYNC_DEPTH 4

`endif

// ==== logic/i2c_slave_fsm.sv ====
////////////////////////////////////////////////////////////////////////////
// protocol FSM of the I2C target
// issues counter and shifter strobes, stretches SCL after each byte
// and owns the host flags; the host answers with addr_or_data_load
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2c_slave_fsm (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     start,
    input  logic     addr_or_data_load,
    i2c_line_if.dst  line,
    i2c_ctl_if.ctl   ctl,
    output logic     data_ready,
    output logic     data_request,
    output logic     i2c_addr_match,
    output logic     no_ack_flag,
    output logic     scl_out
);

    i2c_slave_pkg::slave_state_e state;
    i2c_slave_pkg::slave_state_e next_state;

    logic set_ready;
    logic clr_ready;
    logic set_request;
    logic set_match;
    logic clr_match;
    logic set_no_ack;
    logic clr_no_ack;
    logic scl_high;
    logic scl_low;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= i2c_slave_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state     = state;
        ctl.load_count = 1'b0;
        ctl.dec_count  = 1'b0;
        ctl.shift_in   = 1'b0;
        ctl.load_dir   = 1'b0;
        ctl.shift_out  = 1'b0;
        ctl.sda_low    = 1'b0;
        ctl.sda_high   = 1'b0;
        set_ready      = 1'b0;
        clr_ready      = 1'b0;
        set_request    = 1'b0;
        set_match      = 1'b0;
        clr_match      = 1'b0;
        set_no_ack     = 1'b0;
        clr_no_ack     = 1'b0;
        scl_high       = 1'b0;
        scl_low        = 1'b0;

        unique case (state)
            i2c_slave_pkg::idle: begin
                scl_high     = 1'b1;
                ctl.sda_high = 1'b1;
                clr_match    = 1'b1;
                clr_ready    = 1'b1;
                clr_no_ack   = 1'b1;
                if (start) begin
                    next_state = i2c_slave_pkg::listen;
                end
            end
            // wait for a start condition on the bus
            i2c_slave_pkg::listen: begin
                ctl.load_count = 1'b1;
                scl_high       = 1'b1;
                ctl.sda_high   = 1'b1;
                clr_match      = 1'b1;
                clr_ready      = 1'b1;
                if (line.sda_fall && line.scl_level) begin
                    next_state = i2c_slave_pkg::addr;
                end
            end
            i2c_slave_pkg::addr: begin
                clr_no_ack = 1'b1;
                if (line.scl_rise) begin
                    ctl.shift_in  = 1'b1;
                    ctl.dec_count = 1'b1;
                    if (ctl.count_zero) begin
                        next_state = i2c_slave_pkg::addr_ack;
                    end
                end
            end
            // a mismatch stays silent and leaves SDA high
            i2c_slave_pkg::addr_ack: begin
                ctl.load_dir = 1'b1;
                if (line.scl_fall) begin
                    if (ctl.addr_hit) begin
                        set_match   = 1'b1;
                        ctl.sda_low = 1'b1;
                        next_state  = i2c_slave_pkg::turn;
                    end else begin
                        next_state  = i2c_slave_pkg::listen;
                    end
                end
            end
            i2c_slave_pkg::turn: begin
                ctl.load_count = 1'b1;
                if (line.scl_fall) begin
                    ctl.sda_high = 1'b1;
                    if (ctl.dir_read) begin
                        scl_low     = 1'b1;
                        set_request = 1'b1;
                        next_state  = i2c_slave_pkg::read_stretch;
                    end else begin
                        next_state  = i2c_slave_pkg::write;
                    end
                end
            end
            i2c_slave_pkg::write: begin
                if (line.start_seen) begin
                    // repeated start
                    ctl.load_count = 1'b1;
                    scl_high       = 1'b1;
                    ctl.sda_high   = 1'b1;
                    clr_match      = 1'b1;
                    clr_ready      = 1'b1;
                    next_state     = i2c_slave_pkg::addr;
                end else if (line.scl_rise) begin
                    ctl.shift_in  = 1'b1;
                    ctl.dec_count = 1'b1;
                    if (ctl.count_zero) begin
                        set_ready  = 1'b1;
                        next_state = i2c_slave_pkg::write_ack;
                    end
                end
            end
            // ack and start stretching on the same SCL fall
            i2c_slave_pkg::write_ack: begin
                if (line.scl_fall) begin
                    ctl.sda_low = 1'b1;
                    scl_low     = 1'b1;
                    next_state  = i2c_slave_pkg::write_stretch;
                end
            end
            i2c_slave_pkg::write_stretch: begin
                if (!data_ready) begin
                    scl_high = 1'b1;
                    if (line.scl_fall) begin
                        ctl.sda_high   = 1'b1;
                        ctl.load_count = 1'b1;
                        next_state     = i2c_slave_pkg::write;
                    end
                end
            end
            i2c_slave_pkg::read_stretch: begin
                ctl.load_count = 1'b1;
                if (!data_request) begin
                    scl_high      = 1'b1;
                    ctl.shift_out = 1'b1;
                    next_state    = i2c_slave_pkg::read;
                end
            end
            // next bit on every fall until the eighth fall releases SDA
            i2c_slave_pkg::read: begin
                if (line.scl_fall) begin
                    ctl.shift_out = 1'b1;
                    ctl.dec_count = 1'b1;
                    if (ctl.count_zero) begin
                        next_state = i2c_slave_pkg::read_ack;
                    end
                end
            end
            i2c_slave_pkg::read_ack: begin
                ctl.sda_high = 1'b1;
                if (line.scl_rise) begin
                    if (line.sda_level) begin
                        set_no_ack = 1'b1;
                        next_state = i2c_slave_pkg::listen;
                    end else begin
                        set_request = 1'b1;
                        next_state  = i2c_slave_pkg::read_ack_ext;
                    end
                end
            end
            i2c_slave_pkg::read_ack_ext: begin
                if (line.scl_fall) begin
                    scl_low    = 1'b1;
                    next_state = i2c_slave_pkg::read_stretch;
                end
            end
            default: begin
                next_state = i2c_slave_pkg::idle;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////////
    // host flags and SCL drive
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_ready     <= 1'b0;
            data_request   <= 1'b0;
            i2c_addr_match <= 1'b0;
            no_ack_flag    <= 1'b0;
            scl_out        <= 1'b0;
        end else begin
            // host load pulse clears either request flag
            if (clr_ready || addr_or_data_load) begin
                data_ready <= 1'b0;
            end else if (set_ready) begin
                data_ready <= 1'b1;
            end
            if (addr_or_data_load) begin
                data_request <= 1'b0;
            end else if (set_request) begin
                data_request <= 1'b1;
            end
            if (set_match) begin
                i2c_addr_match <= 1'b1;
            end else if (clr_match) begin
                i2c_addr_match <= 1'b0;
            end
            if (set_no_ack) begin
                no_ack_flag <= 1'b1;
            end else if (clr_no_ack) begin
                no_ack_flag <= 1'b0;
            end
            if (scl_high) begin
                scl_out <= 1'b1;
            end else if (scl_low) begin
                scl_out <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/i2c_slave_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// types that describe the controller itself
// FSM state encoding and the bit index within a byte
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "i2c_slave_consts.svh"

package i2c_slave_pkg;

    typedef logic [$clog2(`I2C_DATA_LEN)-1:0] bit_count_t;

    typedef enum logic [3:0] {
        idle,
        listen,
        addr,
        addr_ack,
        // last SCL low of the address ack, picks the direction
        turn,
        write,
        write_ack,
        write_stretch,
        read_stretch,
        read,
        read_ack,
        read_ack_ext
    } slave_state_e;

endpackage

`default_nettype wire

// ==== sim/i2c_bus_model.svh ====
////////////////////////////////////////////////////////////////////////////
// master side of the I2C bus for the testbench
// included inside the testbench module, drives sda_m and scl_m
// every task waits while SCL is held low by the target
////////////////////////////////////////////////////////////////////////////

`ifndef I2C_BUS_MODEL_SVH
`define I2C_BUS_MODEL_SVH

// core clocks per SCL half period
localparam int half_clocks = 16;

// returns with stretched set when the target held SCL low
task automatic wait_scl_high(output logic stretched);
    int cnt;
    cnt = 0;
    while (scl_line !== 1'b1) begin
        wait_clocks(1);
        cnt++;
    end
    stretched = (cnt > 2);
endtask

// SCL is low on entry and on exit
task automatic write_bit(input logic b, output logic stretched);
    wait_clocks(4);
    sda_m = b;
    wait_clocks(half_clocks - 4);
    scl_m = 1'b1;
    wait_scl_high(stretched);
    wait_clocks(half_clocks);
    scl_m = 1'b0;
endtask

task automatic read_bit(output logic b, output logic stretched);
    wait_clocks(4);
    sda_m = 1'b1;
    wait_clocks(half_clocks - 4);
    scl_m = 1'b1;
    wait_scl_high(stretched);
    // sample in the middle of the high phase
    wait_clocks(half_clocks / 2);
    b = sda_line;
    wait_clocks(half_clocks / 2);
    scl_m = 1'b0;
endtask

// bus idle on entry, SCL low on exit
task automatic send_start();
    wait_clocks(half_clocks);
    sda_m = 1'b0;
    wait_clocks(half_clocks);
    scl_m = 1'b0;
endtask

task automatic send_repeated_start();
    logic s;
    wait_clocks(4);
    sda_m = 1'b1;
    wait_clocks(half_clocks - 4);
    scl_m = 1'b1;
    wait_scl_high(s);
    wait_clocks(half_clocks);
    sda_m = 1'b0;
    wait_clocks(half_clocks);
    scl_m = 1'b0;
endtask

task automatic send_stop();
    logic s;
    wait_clocks(4);
    sda_m = 1'b0;
    wait_clocks(half_clocks - 4);
    scl_m = 1'b1;
    wait_scl_high(s);
    wait_clocks(half_clocks);
    sda_m = 1'b1;
    wait_clocks(half_clocks);
endtask

// eight bits MSB first, then the target's ack bit
task automatic write_byte(input i2c_bus_pkg::i2c_byte_t b, output logic ack,
                          output logic stretched);
    logic s;
    for (int i = 7; i >= 0; i--) begin
        write_bit(b[i], s);
    end
    read_bit(ack, stretched);
endtask

task automatic send_address(input i2c_bus_pkg::i2c_addr_t a, input logic rnw,
                            output logic ack);
    logic s;
    write_byte({a, rnw}, ack, s);
endtask

task automatic read_byte(output i2c_bus_pkg::i2c_byte_t b, input logic ack);
    logic s;
    for (int i = 7; i >= 0; i--) begin
        read_bit(b[i], s);
    end
    write_bit(ack, s);
endtask

`endif

// ==== sim/tb_i2c_slave.sv ====
////////////////////////////////////////////////////////////////////////////
// directed testbench for the I2C target controller
// a master bus model drives the wired-AND lines, a host process answers
// data_ready and data_request with addr_or_data_load
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_i2c_slave;

    // bytes on the bus over all tests
    localparam int max_bytes   = 13;
    localparam int cycle_limit = max_bytes * 9 * 32 * 4 + 2000;
    localparam int host_delay  = 40;

    logic clk;
    logic reset_n;
    logic start;
    logic addr_or_data_load;
    logic sda_m;
    logic scl_m;
    logic sda_line;
    logic scl_line;
    logic data_request;
    logic i2c_addr_match;
    logic data_ready;
    logic no_ack_flag;
    logic sda_out;
    logic scl_out;
    i2c_bus_pkg::i2c_byte_t outbound_data;
    i2c_bus_pkg::i2c_byte_t host_byte;
    i2c_bus_pkg::i2c_byte_t incoming_data;
    i2c_bus_pkg::i2c_addr_t start_addr;
    i2c_bus_pkg::i2c_byte_t rx_q[$];
    i2c_bus_pkg::i2c_byte_t tx_q[$];
    int req_count;
    int cycle_count;
    integer seed;

    // wired-AND bus
    assign sda_line = sda_m & sda_out;
    assign scl_line = scl_m & scl_out;

    // start pulse carries the target address on outbound_data
    assign outbound_data = start ? {1'b0, start_addr} : host_byte;

    i2c_slave dut_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .start             (start),
        .outbound_data     (outbound_data),
        .addr_or_data_load (addr_or_data_load),
        .data_request      (data_request),
        .i2c_addr_match    (i2c_addr_match),
        .data_ready        (data_ready),
        .incoming_data     (incoming_data),
        .no_ack_flag       (no_ack_flag),
        .sda_in            (sda_line),
        .scl_in            (scl_line),
        .sda_out           (sda_out),
        .scl_out           (scl_out)
    );

    always #50 clk = ~clk;

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    `include "i2c_bus_model.svh"

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_byte(input string name, input i2c_bus_pkg::i2c_byte_t got,
                              input i2c_bus_pkg::i2c_byte_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "error");
    endtask

    task automatic host_start(input i2c_bus_pkg::i2c_addr_t a);
        start_addr = a;
        start      = 1'b1;
        wait_clocks(1);
        start      = 1'b0;
    endtask

    // host model samples the flags on the falling clock edge
    initial begin
        forever begin
            @(negedge clk);
            if (data_ready === 1'b1) begin
                rx_q.push_back(incoming_data);
                repeat (host_delay) @(posedge clk);
                #10 addr_or_data_load = 1'b1;
                @(posedge clk);
                #10 addr_or_data_load = 1'b0;
            end else if (data_request === 1'b1) begin
                if (tx_q.size() == 0) begin
                    report_error("target requested a byte but the host had none queued");
                end
                repeat (host_delay) @(posedge clk);
                #10;
                host_byte         = tx_q.pop_front();
                req_count         = req_count + 1;
                addr_or_data_load = 1'b1;
                @(posedge clk);
                #10 addr_or_data_load = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run hung and the tests did not complete");
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        check_bit("data_ready", data_ready, 1'b0);
        check_bit("data_request", data_request, 1'b0);
        check_bit("i2c_addr_match", i2c_addr_match, 1'b0);
        check_bit("no_ack_flag", no_ack_flag, 1'b0);
        wait_clocks(2);
        check_bit("sda_out", sda_out, 1'b1);
        check_bit("scl_out", scl_out, 1'b1);
        wait_clocks(8);
    endtask

    task automatic test_addr_mismatch();
        logic ack;
        host_start(7'h2a);
        send_start();
        send_address(7'h55, 1'b0, ack);
        check_bit("address ack", ack, 1'b1);
        check_bit("i2c_addr_match", i2c_addr_match, 1'b0);
        send_stop();
    endtask

    task automatic test_write();
        logic ack;
        logic stretched;
        i2c_bus_pkg::i2c_byte_t b;
        host_start(7'h2a);
        send_start();
        send_address(7'h2a, 1'b0, ack);
        check_bit("address ack", ack, 1'b0);
        check_bit("i2c_addr_match", i2c_addr_match, 1'b1);
        for (int i = 0; i < 3; i++) begin
            b = i2c_bus_pkg::i2c_byte_t'($random(seed));
            write_byte(b, ack, stretched);
            check_bit("data ack", ack, 1'b0);
            check_bit("scl stretched", stretched, 1'b1);
            check_bit("data_ready", data_ready, 1'b0);
            if (rx_q.size() != 1) begin
                report_error("data_ready was not raised for a written byte");
            end
            check_byte("incoming_data", rx_q.pop_front(), b);
        end
        send_stop();
    endtask

    task automatic test_read();
        logic ack;
        i2c_bus_pkg::i2c_byte_t exp[3];
        i2c_bus_pkg::i2c_byte_t got;
        req_count = 0;
        for (int i = 0; i < 3; i++) begin
            exp[i] = i2c_bus_pkg::i2c_byte_t'($random(seed));
            tx_q.push_back(exp[i]);
        end
        host_start(7'h2a);
        send_start();
        send_address(7'h2a, 1'b1, ack);
        check_bit("address ack", ack, 1'b0);
        check_bit("i2c_addr_match", i2c_addr_match, 1'b1);
        for (int i = 0; i < 3; i++) begin
            // nack on the last byte only
            read_byte(got, i == 2);
            check_byte("read data", got, exp[i]);
        end
        check_bit("no_ack_flag", no_ack_flag, 1'b1);
        check_bit("data_request", data_request, 1'b0);
        if (req_count != 3) begin
            report_error("data_request did not rise once per read byte");
        end
        send_stop();
    endtask

    task automatic test_repeated_start();
        logic ack;
        logic stretched;
        i2c_bus_pkg::i2c_byte_t wb;
        i2c_bus_pkg::i2c_byte_t rb;
        i2c_bus_pkg::i2c_byte_t got;
        wb = i2c_bus_pkg::i2c_byte_t'($random(seed));
        rb = i2c_bus_pkg::i2c_byte_t'($random(seed));
        host_start(7'h2a);
        send_start();
        send_address(7'h2a, 1'b0, ack);
        check_bit("address ack", ack, 1'b0);
        write_byte(wb, ack, stretched);
        check_bit("data ack", ack, 1'b0);
        if (rx_q.size() != 1) begin
            report_error("data_ready was not raised for a written byte");
        end
        check_byte("incoming_data", rx_q.pop_front(), wb);
        tx_q.push_back(rb);
        send_repeated_start();
        send_address(7'h2a, 1'b1, ack);
        check_bit("repeated start address ack", ack, 1'b0);
        read_byte(got, 1'b1);
        check_byte("read data after repeated start", got, rb);
        send_stop();
    endtask

    initial begin
        clk               = 1'b0;
        reset_n           = 1'b0;
        start             = 1'b0;
        addr_or_data_load = 1'b0;
        sda_m             = 1'b1;
        scl_m             = 1'b1;
        start_addr        = '0;
        host_byte         = '0;
        req_count         = 0;
        cycle_count       = 0;
        seed              = 82;
        repeat (4) @(posedge clk);
        #10 reset_n = 1'b1;

        test_reset();
        test_addr_mismatch();
        test_write();
        test_read();
        test_repeated_start();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
+incdir+sim
logic/i2c_bus_pkg.sv
logic/i2c_slave_pkg.sv
logic/i2c_line_if.sv
logic/i2c_ctl_if.sv
logic/i2c_line_sampler.sv
logic/i2c_bit_counter.sv
logic/i2c_byte_shifter.sv
logic/i2c_slave_fsm.sv
logic/i2c_slave.sv
sim/tb_i2c_slave.sv
